// File: rtl/ppu_types_pkg.sv
`default_nettype none

package ppu_types_pkg;

  // ====================
  // VRAM side
  // ====================

  // Byte address into the 8 KB video RAM
  typedef logic [12:0] vram_addr_t;

  // One VRAM byte
  typedef logic [7:0] vram_data_t;

  // ====================
  // Pixel side
  // ====================

  // Background color index, before palette
  typedef logic [1:0] gb_color_t;

  // Shade after palette lookup
  typedef logic [1:0] shade_t;

  // Four 2-bit fields, field n is the shade for color n
  typedef logic [7:0] palette_t;

  // Pixel position within a line
  typedef logic [7:0] pixel_count_t;

  // Scroll registers and line number
  typedef logic [7:0] scroll_t;

endpackage

`default_nettype wire

// File: rtl/ppu_util_pkg.sv
`default_nettype none

package ppu_util_pkg;

  import ppu_types_pkg::*;

  // ====================
  // Tile geometry
  // ====================

  // One tile row is eight pixels wide
  localparam int FIFO_DEPTH = 8;
  // Two plane bytes per row, eight rows
  localparam int TILE_BYTES = 16;

  // Background map bases
  localparam vram_addr_t MAP_BASE_0 = 13'h1800;
  localparam vram_addr_t MAP_BASE_1 = 13'h1C00;
  // Tile 0 of the signed addressing mode
  localparam vram_addr_t SIGNED_DATA_BASE = 13'h1000;

  // ====================
  // Decode helpers
  // ====================

  // Merge plane bytes into eight color indices
  // Element FIFO_DEPTH-1 is the leftmost pixel (bit 7)
  function automatic gb_color_t [FIFO_DEPTH-1:0] decode_tile_row(input vram_data_t lo,
                                                                 input vram_data_t hi);
    gb_color_t [FIFO_DEPTH-1:0] row;
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      // High plane supplies the upper index bit
      row[i] = {hi[i], lo[i]};
    end
    return row;
  endfunction

  // Color index to shade through the palette register
  function automatic shade_t apply_palette(input gb_color_t color, input palette_t pal);
    return pal[{color, 1'b0} +: 2];
  endfunction

endpackage

`default_nettype wire

// File: rtl/bg_tile_fetcher.sv
`default_nettype none

module bg_tile_fetcher (
  input  logic                                                  clk,
  input  logic                                                  reset,
  input  logic                                                  flush,
  input  ppu_types_pkg::scroll_t                                ly,
  input  ppu_types_pkg::scroll_t                                scx,
  input  ppu_types_pkg::scroll_t                                scy,
  input  logic                                                  map_sel,
  input  logic                                                  data_sel,
  output logic                                                  vram_rd,
  output ppu_types_pkg::vram_addr_t                             vram_addr,
  input  ppu_types_pkg::vram_data_t                             vram_data,
  input  logic                                                  fifo_empty,
  output logic                                                  fifo_write_en,
  output ppu_types_pkg::gb_color_t [ppu_util_pkg::FIFO_DEPTH-1:0] fifo_write_data
);

  import ppu_types_pkg::*;
  import ppu_util_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_map,
    st_data_lo,
    st_data_hi,
    st_push
  } fetch_state_t;

  fetch_state_t state;
  // Second cycle of a read, data on the bus
  logic         rd_wait;
  // Tile position counted from the line start
  logic [4:0]   tile_idx;
  vram_data_t   tile_num;
  vram_data_t   plane_lo;
  vram_data_t   plane_hi;
  scroll_t      line_y;
  logic [4:0]   tile_col;
  logic [3:0]   row_off;
  vram_addr_t   map_addr;
  vram_addr_t   data_addr;

  // ====================
  // Address generation
  // ====================

  // Background line, wraps at 256
  assign line_y   = ly + scy;
  // Column wraps at 32 tiles
  assign tile_col = scx[7:3] + tile_idx;
  assign map_addr = (map_sel ? MAP_BASE_1 : MAP_BASE_0) + vram_addr_t'({line_y[7:3], tile_col});

  // Fine row and plane select
  assign row_off = {line_y[2:0], state == st_data_hi};

  always_comb begin
    if (data_sel) begin
      // Unsigned tile numbers from 0x0000
      data_addr = vram_addr_t'(tile_num * TILE_BYTES) + vram_addr_t'(row_off);
    end else begin
      // Signed tile numbers around 0x1000, wraps in 13 bits
      data_addr = SIGNED_DATA_BASE + vram_addr_t'($signed(tile_num) * TILE_BYTES)
                + vram_addr_t'(row_off);
    end
  end

  assign vram_addr = (state == st_map) ? map_addr : data_addr;
  assign vram_rd   = !rd_wait && (state == st_map || state == st_data_lo || state == st_data_hi);

  // Push only into an empty FIFO
  assign fifo_write_en   = (state == st_push) && fifo_empty;
  assign fifo_write_data = decode_tile_row(plane_lo, plane_hi);

  // ====================
  // Fetch FSM
  // ====================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= st_idle;
      rd_wait  <= 1'b0;
      tile_idx <= '0;
    end else if (flush) begin
      // New line restarts at the first map entry
      state    <= st_map;
      rd_wait  <= 1'b0;
      tile_idx <= '0;
    end else begin
      case (state)
        st_idle: begin
          // Wait for the first line
        end
        st_map, st_data_lo, st_data_hi: begin
          rd_wait <= !rd_wait;
          if (rd_wait) begin
            case (state)
              st_map:     state <= st_data_lo;
              st_data_lo: state <= st_data_hi;
              default:    state <= st_push;
            endcase
          end
        end
        st_push: begin
          if (fifo_empty) begin
            state    <= st_map;
            tile_idx <= tile_idx + 5'd1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Capture read data in the second cycle of each read
  always_ff @(posedge clk) begin
    if (rd_wait) begin
      case (state)
        st_map:     tile_num <= vram_data;
        st_data_lo: plane_lo <= vram_data;
        st_data_hi: plane_hi <= vram_data;
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/pixel_fifo.sv
`default_nettype none

module pixel_fifo (
  input  logic                                                  clk,
  input  logic                                                  reset,
  input  logic                                                  flush,
  input  logic                                                  write_en,
  input  ppu_types_pkg::gb_color_t [ppu_util_pkg::FIFO_DEPTH-1:0] write_data,
  output ppu_types_pkg::gb_color_t [ppu_util_pkg::FIFO_DEPTH-1:0] read_data,
  output logic                                                  empty,
  output logic                                                  full,
  input  logic                                                  read_en
);

  import ppu_types_pkg::*;
  import ppu_util_pkg::*;

  // Count runs 0 or FIFO_DEPTH
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  gb_color_t [FIFO_DEPTH-1:0] buffer;
  logic [CW-1:0]              count;

  logic do_write;
  logic do_read;

  // Bulk write needs an empty FIFO
  assign do_write = write_en && empty;
  // Whole-row read
  assign do_read  = read_en && !empty;

  // ====================
  // Row storage
  // ====================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      buffer <= '0;
    end else if (flush) begin
      buffer <= '0;
    end else if (do_write) begin
      // All eight pixels in one cycle
      buffer <= write_data;
    end
  end

  // Row stays readable until the next write
  assign read_data = buffer;

  // ====================
  // Occupancy
  // ====================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= '0;
    end else if (flush) begin
      count <= '0;
    end else if (do_write) begin
      count <= CW'(FIFO_DEPTH);
    end else if (do_read) begin
      // One read drains the row
      count <= '0;
    end
  end

  assign empty = (count == '0);
  assign full  = (count == CW'(FIFO_DEPTH));

endmodule

`default_nettype wire

// File: rtl/pixel_shifter.sv
`default_nettype none

module pixel_shifter #(
  parameter int LINE_WIDTH = 160
) (
  input  logic                                                  clk,
  input  logic                                                  reset,
  input  logic                                                  flush,
  input  logic [2:0]                                            scx_fine,
  input  ppu_types_pkg::palette_t                               bgp,
  output logic                                                  fifo_read_en,
  input  ppu_types_pkg::gb_color_t [ppu_util_pkg::FIFO_DEPTH-1:0] fifo_read_data,
  input  logic                                                  fifo_empty,
  output logic                                                  pixel_valid,
  output ppu_types_pkg::shade_t                                 pixel_shade,
  output logic                                                  line_done
);

  import ppu_types_pkg::*;
  import ppu_util_pkg::*;

  localparam int CW = $clog2(FIFO_DEPTH + 1);

  gb_color_t [FIFO_DEPTH-1:0] row;
  // Pixels still in the row register
  logic [CW-1:0]              row_left;
  // Fine-scroll pixels still to drop
  logic [2:0]                 discard;
  logic                       first_row;
  logic                       active;
  pixel_count_t               pix_count;
  logic                       last_pix;
  logic                       shift_en;
  logic                       at_last;

  // Ask for a row once the current one is used up
  assign fifo_read_en = active && (row_left == '0) && !fifo_empty;
  assign shift_en     = active && (row_left != '0);
  assign at_last      = (pix_count == pixel_count_t'(LINE_WIDTH - 1));

  // ====================
  // Line control
  // ====================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      active      <= 1'b0;
      first_row   <= 1'b0;
      row_left    <= '0;
      discard     <= '0;
      pix_count   <= '0;
      pixel_valid <= 1'b0;
      last_pix    <= 1'b0;
      line_done   <= 1'b0;
    end else if (flush) begin
      // Line restart, any row in flight is dropped
      active      <= 1'b1;
      first_row   <= 1'b1;
      row_left    <= '0;
      discard     <= '0;
      pix_count   <= '0;
      pixel_valid <= 1'b0;
      last_pix    <= 1'b0;
      line_done   <= 1'b0;
    end else begin
      pixel_valid <= 1'b0;
      last_pix    <= 1'b0;
      // Done one cycle after the final pixel
      line_done   <= last_pix;
      if (fifo_read_en) begin
        row_left  <= CW'(FIFO_DEPTH);
        first_row <= 1'b0;
        // Scroll settings are stable by the first load
        if (first_row) begin
          discard <= scx_fine;
        end
      end else if (shift_en) begin
        row_left <= row_left - 1'b1;
        if (discard != '0) begin
          // Hidden scroll pixel, no strobe
          discard <= discard - 1'b1;
        end else begin
          pixel_valid <= 1'b1;
          pix_count   <= pix_count + 1'b1;
          if (at_last) begin
            last_pix <= 1'b1;
            active   <= 1'b0;
          end
        end
      end
    end
  end

  // ====================
  // Row and shade path
  // ====================

  always_ff @(posedge clk) begin
    if (fifo_read_en) begin
      row <= fifo_read_data;
    end else if (shift_en) begin
      // Leftmost pixel out of the top element
      row         <= {row[FIFO_DEPTH-2:0], gb_color_t'(0)};
      pixel_shade <= apply_palette(row[FIFO_DEPTH-1], bgp);
    end
  end

endmodule

`default_nettype wire

// File: rtl/bg_pixel_pipe.sv
`default_nettype none

module bg_pixel_pipe #(
  parameter int LINE_WIDTH = 160
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       line_start,
  input  ppu_types_pkg::scroll_t     ly,
  input  ppu_types_pkg::scroll_t     scx,
  input  ppu_types_pkg::scroll_t     scy,
  input  logic                       map_sel,
  input  logic                       data_sel,
  input  ppu_types_pkg::palette_t    bgp,
  output logic                       vram_rd,
  output ppu_types_pkg::vram_addr_t  vram_addr,
  input  ppu_types_pkg::vram_data_t  vram_data,
  output logic                       pixel_valid,
  output ppu_types_pkg::shade_t      pixel_shade,
  output logic                       line_done
);

  import ppu_types_pkg::*;
  import ppu_util_pkg::*;

  // Settings held for the whole line
  scroll_t  ly_q;
  scroll_t  scx_q;
  scroll_t  scy_q;
  logic     map_sel_q;
  logic     data_sel_q;
  palette_t bgp_q;

  logic                       flush;
  logic                       fifo_write_en;
  logic                       fifo_read_en;
  logic                       fifo_empty;
  gb_color_t [FIFO_DEPTH-1:0] fifo_write_data;
  gb_color_t [FIFO_DEPTH-1:0] fifo_read_data;

  // Line start restarts the whole pipe
  assign flush = line_start;

  always_ff @(posedge clk) begin
    if (line_start) begin
      ly_q       <= ly;
      scx_q      <= scx;
      scy_q      <= scy;
      map_sel_q  <= map_sel;
      data_sel_q <= data_sel;
      bgp_q      <= bgp;
    end
  end

  // ====================
  // Fetch, buffer, shift
  // ====================

  bg_tile_fetcher fetcher_i (
    .clk             (clk),
    .reset           (reset),
    .flush           (flush),
    .ly              (ly_q),
    .scx             (scx_q),
    .scy             (scy_q),
    .map_sel         (map_sel_q),
    .data_sel        (data_sel_q),
    .vram_rd         (vram_rd),
    .vram_addr       (vram_addr),
    .vram_data       (vram_data),
    .fifo_empty      (fifo_empty),
    .fifo_write_en   (fifo_write_en),
    .fifo_write_data (fifo_write_data)
  );

  // Full flag not needed, fetcher waits on empty
  pixel_fifo fifo_i (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .write_en   (fifo_write_en),
    .write_data (fifo_write_data),
    .read_data  (fifo_read_data),
    .empty      (fifo_empty),
    .full       (),
    .read_en    (fifo_read_en)
  );

  pixel_shifter #(
    .LINE_WIDTH (LINE_WIDTH)
  ) shifter_i (
    .clk            (clk),
    .reset          (reset),
    .flush          (flush),
    .scx_fine       (scx_q[2:0]),
    .bgp            (bgp_q),
    .fifo_read_en   (fifo_read_en),
    .fifo_read_data (fifo_read_data),
    .fifo_empty     (fifo_empty),
    .pixel_valid    (pixel_valid),
    .pixel_shade    (pixel_shade),
    .line_done      (line_done)
  );

endmodule

`default_nettype wire

// File: tb/bg_ref_model.svh
`ifndef BG_REF_MODEL_SVH
`define BG_REF_MODEL_SVH

// ====================
// Background line model
// ====================

// Works from the latched line settings ref_* and the VRAM array

// Tile map entry of tile n in the line
function automatic vram_addr_t map_entry_addr(input int n);
  int tile_row;
  int tile_col;
  int base;
  // Background line wraps at 256
  tile_row = ((int'(ref_ly) + int'(ref_scy)) % 256) / 8;
  // Map is 32 tiles wide
  tile_col = (int'(ref_scx) / 8 + n) % 32;
  base = ref_map_sel ? 32'h1C00 : 32'h1800;
  return vram_addr_t'(base + 32 * tile_row + tile_col);
endfunction

// Plane byte of tile n, hi picks the upper plane
function automatic vram_addr_t plane_addr(input int n, input bit hi);
  int tile_num;
  int fine_row;
  int addr;
  fine_row = (int'(ref_ly) + int'(ref_scy)) % 8;
  tile_num = int'(vram_mem[map_entry_addr(n)]);
  if (ref_data_sel) begin
    addr = tile_num * 16;
  end else begin
    // Tile numbers 128 and up sit below the signed base
    if (tile_num > 127) begin
      tile_num = tile_num - 256;
    end
    addr = 32'h1000 + tile_num * 16;
  end
  return vram_addr_t'(addr + 2 * fine_row + int'(hi));
endfunction

// Read idx of the line, three reads per tile
function automatic vram_addr_t read_addr_at(input int idx);
  if (idx % 3 == 0) begin
    return map_entry_addr(idx / 3);
  end
  return plane_addr(idx / 3, idx % 3 == 2);
endfunction

// Shade of visible pixel p, fine scroll skipped
function automatic shade_t shade_at(input int p);
  int x;
  int bit_pos;
  int color;
  vram_data_t lo;
  vram_data_t hi;
  x = int'(ref_scx[2:0]) + p;
  lo = vram_mem[plane_addr(x / 8, 1'b0)];
  hi = vram_mem[plane_addr(x / 8, 1'b1)];
  // Leftmost pixel is bit 7
  bit_pos = 7 - x % 8;
  color = 2 * int'((hi >> bit_pos) & 8'h01) + int'((lo >> bit_pos) & 8'h01);
  return shade_t'(ref_bgp >> (2 * color));
endfunction

`endif

// File: tb/tb_bg_pixel_pipe.sv
`default_nettype none

module tb_bg_pixel_pipe;

  import ppu_types_pkg::*;

  localparam int LINE_WIDTH = 32;
  // Every line_start of the run, aborted lines too
  localparam int NUM_LINES = 30;
  localparam int GAP_CYCLES = 16;

  logic       clk;
  logic       reset;
  logic       line_start;
  scroll_t    ly;
  scroll_t    scx;
  scroll_t    scy;
  logic       map_sel;
  logic       data_sel;
  palette_t   bgp;
  logic       vram_rd;
  vram_addr_t vram_addr;
  vram_data_t vram_data;
  logic       pixel_valid;
  shade_t     pixel_shade;
  logic       line_done;

  // VRAM contents
  vram_data_t vram_mem [0:8191];
  // Settings of the line being checked
  scroll_t    ref_ly;
  scroll_t    ref_scx;
  scroll_t    ref_scy;
  logic       ref_map_sel;
  logic       ref_data_sel;
  palette_t   ref_bgp;

  logic [31:0] rng_state = 32'd5;
  int          pix_idx = 0;
  int          read_idx = 0;
  int          lines_done = 0;
  bit          line_seen = 1'b0;
  bit          prev_valid = 1'b0;

  `include "bg_ref_model.svh"

  bg_pixel_pipe #(
    .LINE_WIDTH (LINE_WIDTH)
  ) dut_i (
    .clk         (clk),
    .reset       (reset),
    .line_start  (line_start),
    .ly          (ly),
    .scx         (scx),
    .scy         (scy),
    .map_sel     (map_sel),
    .data_sel    (data_sel),
    .bgp         (bgp),
    .vram_rd     (vram_rd),
    .vram_addr   (vram_addr),
    .vram_data   (vram_data),
    .pixel_valid (pixel_valid),
    .pixel_shade (pixel_shade),
    .line_done   (line_done)
  );

  // ====================
  // Helpers
  // ====================

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic shade_check(input string name, input shade_t got, input shade_t want);
    if (got !== want) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, want);
      abort_run();
    end
  endtask

  task automatic addr_check(input string name, input vram_addr_t got, input vram_addr_t want);
    if (got !== want) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, want);
      abort_run();
    end
  endtask

  task automatic count_check(input string name, input pixel_count_t got,
                             input pixel_count_t want);
    if (got !== want) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, want);
      abort_run();
    end
  endtask

  // One line, abort_at > 0 leaves it open after that many pixels
  task automatic run_line(input scroll_t new_ly, input scroll_t new_scx, input scroll_t new_scy,
                          input logic new_map, input logic new_data, input palette_t new_bgp,
                          input int abort_at);
    int target;
    target = lines_done + 1;
    @(posedge clk);
    #1;
    line_start = 1'b1;
    ly         = new_ly;
    scx        = new_scx;
    scy        = new_scy;
    map_sel    = new_map;
    data_sel   = new_data;
    bgp        = new_bgp;
    @(posedge clk);
    #1;
    line_start = 1'b0;
    if (abort_at > 0) begin
      while (pix_idx < abort_at) @(posedge clk);
    end else begin
      while (lines_done < target) @(posedge clk);
      // Lets the trailing fetches of the line finish
      repeat (GAP_CYCLES) @(posedge clk);
    end
  endtask

  // ====================
  // Clock, VRAM, watchdog
  // ====================

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Data follows a read strobe from the next edge
  initial begin
    logic       rd_pend;
    vram_addr_t rd_addr;
    vram_data = '0;
    forever begin
      @(negedge clk);
      rd_pend = vram_rd;
      rd_addr = vram_addr;
      @(posedge clk);
      #1;
      if (rd_pend) begin
        vram_data = vram_mem[rd_addr];
      end
    end
  end

  initial begin
    repeat (NUM_LINES * LINE_WIDTH * 12 + 100) @(posedge clk);
    $display("Timeout, the lines did not finish in time");
    abort_run();
  end

  // ====================
  // Monitors
  // ====================

  // Mid-cycle sampling, registered outputs are stable here
  always @(negedge clk) begin
    if (vram_rd) begin
      if (!line_seen) begin
        $display("VRAM read issued before any line_start");
        abort_run();
      end
      addr_check("vram_addr", vram_addr, read_addr_at(read_idx));
      read_idx++;
    end
    if (pixel_valid) begin
      if (!line_seen || pix_idx >= LINE_WIDTH) begin
        $display("Pixel strobe with no pixel left in the line");
        abort_run();
      end
      shade_check("pixel_shade", pixel_shade, shade_at(pix_idx));
      pix_idx++;
    end
    if (line_done) begin
      count_check("pixel count at line_done", pixel_count_t'(pix_idx),
                  pixel_count_t'(LINE_WIDTH));
      if (!prev_valid) begin
        $display("line_done did not come one cycle after the last pixel");
        abort_run();
      end
      lines_done++;
    end
    prev_valid = pixel_valid;
    // Old line checked first, then the new settings take over
    if (line_start) begin
      ref_ly       = ly;
      ref_scx      = scx;
      ref_scy      = scy;
      ref_map_sel  = map_sel;
      ref_data_sel = data_sel;
      ref_bgp      = bgp;
      read_idx     = 0;
      pix_idx      = 0;
      line_seen    = 1'b1;
    end
  end

  // ====================
  // Stimulus
  // ====================

  initial begin
    scroll_t     new_ly;
    scroll_t     new_scx;
    scroll_t     new_scy;
    logic [31:0] r;
    int          row_base;
    reset      = 1'b1;
    line_start = 1'b0;
    ly         = '0;
    scx        = '0;
    scy        = '0;
    map_sel    = 1'b0;
    data_sel   = 1'b0;
    bgp        = '0;
    for (int a = 0; a < 8192; a++) begin
      vram_mem[vram_addr_t'(a)] = vram_data_t'(next_random());
    end
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    // Idle until the first line
    repeat (20) begin
      @(negedge clk);
      if (vram_rd || pixel_valid) begin
        $display("Pipe became active with no line_start");
        abort_run();
      end
    end

    // Unsigned tile data, random settings
    for (int k = 0; k < 12; k++) begin
      r = next_random();
      run_line(scroll_t'(r), scroll_t'(r >> 8), scroll_t'(r >> 16), r[24], 1'b1,
               palette_t'(next_random()), 0);
    end

    // Signed tile data, map row forced to high tile numbers
    for (int k = 0; k < 4; k++) begin
      r = next_random();
      new_ly   = scroll_t'(r);
      new_scy  = scroll_t'(r >> 8);
      row_base = (k % 2 == 0 ? 32'h1800 : 32'h1C00)
               + 32 * (((int'(new_ly) + int'(new_scy)) % 256) / 8);
      for (int c = 0; c < 32; c += 2) begin
        vram_mem[vram_addr_t'(row_base + c)] = vram_mem[vram_addr_t'(row_base + c)] | 8'h80;
      end
      run_line(new_ly, scroll_t'(r >> 16), new_scy, k % 2 == 1, 1'b0,
               palette_t'(next_random()), 0);
    end

    // Fine scroll and wrap past column 31
    for (int k = 0; k < 4; k++) begin
      r = next_random();
      new_scx = scroll_t'(224 + 8 * int'(r[4:3]) + 1 + int'(r[15:8]) % 7);
      run_line(scroll_t'(r >> 16), new_scx, scroll_t'(r >> 24), r[5], r[6],
               palette_t'(next_random()), 0);
    end

    // Map select and palette per line, same position
    r = next_random();
    for (int k = 0; k < 4; k++) begin
      run_line(scroll_t'(r), scroll_t'(r >> 8), scroll_t'(r >> 16), k >= 2, r[24],
               (k % 2 == 0) ? 8'hE4 : 8'h1B, 0);
    end

    // Aborted lines, each followed by a full one
    for (int k = 0; k < 3; k++) begin
      r = next_random();
      run_line(scroll_t'(r), scroll_t'(r >> 8), scroll_t'(r >> 16), r[24], r[25],
               palette_t'(next_random()), 5 + 7 * k);
      r = next_random();
      run_line(scroll_t'(r), scroll_t'(r >> 8), scroll_t'(r >> 16), r[24], r[25],
               palette_t'(next_random()), 0);
    end

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+tb
rtl/ppu_types_pkg.sv
rtl/ppu_util_pkg.sv
rtl/bg_tile_fetcher.sv
rtl/pixel_fifo.sv
rtl/pixel_shifter.sv
rtl/bg_pixel_pipe.sv
tb/tb_bg_pixel_pipe.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the background pixel pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_bg_pixel_pipe -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_bg_pixel_pipe > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Test passed$" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
